/* src/rename_pkg.sv */
// shared widths and record types for the rename stage, referenced by scoped name
`default_nettype none

package rename_pkg;

  // datapath and tag widths
  localparam int xlen = 32;
  localparam int robid_w = 7;
  localparam int arch_regs = 32;
  localparam int reg_w = 5;
  localparam int op_w = 5;
  // word address of an instruction, byte offset dropped
  localparam int pc_w = xlen - 2;

  // one decoded micro-op as handed over by decode
  typedef struct packed {
    logic valid;
    logic [pc_w-1:0] addr;
    logic [op_w-1:0] op;
    logic [robid_w-1:0] robid;
    // top bit set means no destination register
    logic [reg_w:0] rd;
    logic uses_rs1;
    logic uses_rs2;
    logic uses_imm;
    logic uses_memory;
    logic uses_pc;
    logic csr_access;
    logic forward;
    logic inhibit;
    logic [pc_w-1:0] target;
    logic [reg_w-1:0] rs1;
    logic [reg_w-1:0] rs2;
    logic [xlen-1:0] imm;
  } uop_t;

  // operand word, either a value or the tag of a pending producer
  typedef union packed {
    logic [xlen-1:0] value;
    struct packed {
      logic [xlen-robid_w-1:0] pad;
      logic [robid_w-1:0] robid;
    } tag;
  } operand_u;

  // ready selects the value view, otherwise the tag view
  typedef struct packed {
    logic ready;
    operand_u data;
  } src_t;

  // record handed to exe reservation stations, LSQ or CSR unit
  typedef struct packed {
    logic [op_w-1:0] op;
    logic [robid_w-1:0] robid;
    logic [reg_w:0] rd;
    src_t op1;
    src_t op2;
    logic [xlen-1:0] imm;
  } dispatch_t;

endpackage

`default_nettype wire

/* src/rename_latch.sv */
// one-entry input latch of the rename stage, holds the decoded micro-op while stalled
`timescale 1ns/100ps
`default_nettype none

module rename_latch (
  input  wire logic              clk,
  input  wire logic              arst_n,
  input  wire logic              flush,
  input  wire logic              stall,
  input  wire rename_pkg::uop_t  decode_uop,
  output rename_pkg::uop_t       cur_uop
);

  // valid is the only control bit here
  logic uop_valid;
  // payload of the held micro-op
  rename_pkg::uop_t uop_q;

  // flush wins over a new load, even while stalled
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uop_valid <= 1'b0;
    end else if (flush) begin
      uop_valid <= 1'b0;
    end else if (!stall) begin
      uop_valid <= decode_uop.valid;
    end
  end

  // payload follows decode whenever the stage is free to advance
  always_ff @(posedge clk) begin
    if (!stall) begin
      uop_q <= decode_uop;
    end
  end

  // held fields with the separately tracked valid bit
  always_comb begin
    cur_uop = uop_q;
    cur_uop.valid = uop_valid;
  end

endmodule

`default_nettype wire

/* src/alias_table.sv */
// register alias table, maps each register to a value or a pending reorder-buffer tag
`timescale 1ns/100ps
`default_nettype none

module alias_table (
  input  wire logic                               clk,
  input  wire logic                               arst_n,
  input  wire logic                               flush,
  input  wire logic [rename_pkg::reg_w-1:0]       rs1,
  input  wire logic [rename_pkg::reg_w-1:0]       rs2,
  output rename_pkg::src_t                        rs1_src,
  output rename_pkg::src_t                        rs2_src,
  input  wire logic                               alloc,
  input  wire logic [rename_pkg::reg_w:0]         rd,
  input  wire logic [rename_pkg::robid_w-1:0]     robid,
  input  wire logic                               wb_valid,
  input  wire logic [rename_pkg::robid_w-1:0]     wb_robid,
  input  wire logic [rename_pkg::xlen-1:0]        wb_value,
  input  wire logic                               fwd_valid,
  input  wire logic [rename_pkg::robid_w-1:0]     fwd_robid,
  input  wire logic [rename_pkg::xlen-1:0]        fwd_value
);

  logic [rename_pkg::arch_regs-1:0] ready_q;
  logic [rename_pkg::xlen-1:0] value_q [rename_pkg::arch_regs];
  logic [rename_pkg::robid_w-1:0] tag_q [rename_pkg::arch_regs];
  logic alloc_ok;
  logic fwd_self;

  // x0 and "no destination" never get a tag
  assign alloc_ok = alloc & ~rd[rename_pkg::reg_w] & (rd[rename_pkg::reg_w-1:0] != '0);
  // the allocating micro-op forwards its own result in the same cycle
  assign fwd_self = fwd_valid & (fwd_robid == robid);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= '1;
      for (int i = 0; i < rename_pkg::arch_regs; i++) begin
        value_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < rename_pkg::arch_regs; i++) begin
        if (alloc_ok && !flush && int'(rd[rename_pkg::reg_w-1:0]) == i) begin
          // allocation beats a writeback to the same entry
          if (fwd_self) begin
            value_q[i] <= fwd_value;
            ready_q[i] <= 1'b1;
          end else begin
            ready_q[i] <= 1'b0;
          end
        end else if (!ready_q[i] && fwd_valid && tag_q[i] == fwd_robid) begin
          value_q[i] <= fwd_value;
          ready_q[i] <= 1'b1;
        end else if (!ready_q[i] && wb_valid && tag_q[i] == wb_robid) begin
          value_q[i] <= wb_value;
          ready_q[i] <= 1'b1;
        end else if (flush) begin
          // pending tags dropped, last written value shows again
          ready_q[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_ok && !flush && !fwd_self) begin
      tag_q[rd[rename_pkg::reg_w-1:0]] <= robid;
    end
  end

  // pack one entry into the value or tag view
  function automatic rename_pkg::src_t make_src(
    input logic                           is_x0,
    input logic                           ready,
    input logic [rename_pkg::xlen-1:0]    value,
    input logic [rename_pkg::robid_w-1:0] tag
  );
    rename_pkg::src_t src;
    src = '0;
    if (is_x0) begin
      src.ready = 1'b1;
    end else if (ready) begin
      src.ready = 1'b1;
      src.data.value = value;
    end else begin
      src.data.tag.robid = tag;
    end
    return src;
  endfunction

  assign rs1_src = make_src(rs1 == '0, ready_q[rs1], value_q[rs1], tag_q[rs1]);
  assign rs2_src = make_src(rs2 == '0, ready_q[rs2], value_q[rs2], tag_q[rs2]);

endmodule

`default_nettype wire

/* src/operand_select.sv */
// builds both dispatch operands and their ready bits from the held micro-op
`timescale 1ns/100ps
`default_nettype none

module operand_select (
  input  wire rename_pkg::uop_t  cur_uop,
  input  wire rename_pkg::src_t  rs1_src,
  input  wire rename_pkg::src_t  rs2_src,
  output rename_pkg::src_t       op1,
  output rename_pkg::src_t       op2
);

  // byte address of the micro-op
  logic [rename_pkg::xlen-1:0] pc_value;
  // CSR immediate forms carry the constant in the rs1 field
  logic [rename_pkg::xlen-1:0] zimm;

  assign pc_value = {cur_uop.addr, 2'b00};
  assign zimm = {{(rename_pkg::xlen - rename_pkg::reg_w){1'b0}}, cur_uop.rs1};

  always_comb begin
    op1 = '0;
    op2 = '0;
    op1.ready = 1'b1;
    op2.ready = 1'b1;

    if (cur_uop.uses_rs1) begin
      // register forms, operand 1 straight from the RAT
      op1 = rs1_src;
      if (cur_uop.uses_rs2) begin
        // reg-reg ALU ops and stores
        op2 = rs2_src;
      end else if (cur_uop.uses_imm) begin
        // reg-imm ALU, loads, CSR with register source
        op2.data.value = cur_uop.imm;
      end
    end else if (cur_uop.uses_pc) begin
      // AUIPC style, pc plus immediate
      op1.data.value = pc_value;
      op2.data.value = cur_uop.imm;
    end else begin
      // LUI or CSR immediate, operand 2 stays ready zero
      if (cur_uop.csr_access) begin
        op1.data.value = zimm;
      end else begin
        op1.data.value = cur_uop.imm;
      end
    end
  end

endmodule

`default_nettype wire

/* src/dispatch_ctrl.sv */
// picks the consumer for the held micro-op, forms the stall and the allocate/forward strobes
`timescale 1ns/100ps
`default_nettype none

module dispatch_ctrl (
  input  wire rename_pkg::uop_t                   cur_uop,
  input  wire rename_pkg::src_t                   op1,
  input  wire rename_pkg::src_t                   op2,
  input  wire logic [rename_pkg::robid_w-1:0]     rob_head,
  input  wire logic                               csr_busy,
  input  wire logic                               exers_stall,
  input  wire logic                               lsq_stall,
  output logic                                    exers_write,
  output logic                                    lsq_write,
  output logic                                    csr_write,
  output rename_pkg::dispatch_t                   disp,
  output logic                                    stall,
  output logic                                    alloc,
  output logic [rename_pkg::reg_w:0]              alloc_rd,
  output logic                                    fwd_valid,
  output logic                                    wb_inhibit
);

  logic head_match;
  logic csr_pending;
  // micro-op leaves the stage this cycle
  logic go;

  // CSR ops run only once every older instruction has retired
  assign head_match = rob_head == cur_uop.robid;
  assign csr_pending = cur_uop.valid & cur_uop.csr_access;

  // consumer selection, at most one strobe high
  assign exers_write = cur_uop.valid & ~cur_uop.uses_memory & ~cur_uop.csr_access;
  assign lsq_write = cur_uop.valid & cur_uop.uses_memory & ~cur_uop.csr_access;
  assign csr_write = csr_pending & head_match;

  assign stall = (exers_write & exers_stall)
               | (lsq_write & lsq_stall)
               | (csr_pending & ~head_match)
               | csr_busy;

  assign go = cur_uop.valid & ~stall;

  // tag allocation is held back until the micro-op really dispatches
  assign alloc = go & ~cur_uop.rd[rename_pkg::reg_w];
  assign alloc_rd = cur_uop.rd;

  // forwarded result goes to writeback together with the allocation
  assign fwd_valid = go & cur_uop.forward;
  // ROB skips the next writeback, the forwarded data is already in place
  assign wb_inhibit = go & cur_uop.inhibit;

  always_comb begin
    disp.op = cur_uop.op;
    disp.robid = cur_uop.robid;
    // no register write from the consumer when the result is forwarded
    disp.rd = cur_uop.rd | {cur_uop.forward, {rename_pkg::reg_w{1'b0}}};
    disp.op1 = op1;
    disp.op2 = op2;
    disp.imm = cur_uop.imm;
  end

endmodule

`default_nettype wire

/* src/rename_top.sv */
// rename and dispatch stage top, wires latch, RAT, operand select and dispatch control
`timescale 1ns/100ps
`default_nettype none

module rename_top (
  input  wire logic                               clk,
  input  wire logic                               arst_n,
  input  wire logic                               flush,
  input  wire rename_pkg::uop_t                   decode_uop,
  output logic                                    rename_stall,
  input  wire logic [rename_pkg::robid_w-1:0]     rob_head,
  input  wire logic                               csr_busy,
  input  wire logic                               exers_stall,
  input  wire logic                               lsq_stall,
  input  wire logic                               wb_valid,
  input  wire logic [rename_pkg::robid_w-1:0]     wb_robid,
  input  wire logic [rename_pkg::xlen-1:0]        wb_value,
  output logic                                    exers_write,
  output logic                                    lsq_write,
  output logic                                    csr_write,
  output rename_pkg::dispatch_t                   disp,
  output logic                                    rename_wb_valid,
  output logic [rename_pkg::xlen-1:0]             rename_wb_value,
  output logic                                    wb_inhibit
);

  rename_pkg::uop_t cur_uop;
  rename_pkg::src_t rs1_src;
  rename_pkg::src_t rs2_src;
  rename_pkg::src_t op1;
  rename_pkg::src_t op2;
  logic alloc;
  logic [rename_pkg::reg_w:0] alloc_rd;

  // forwarded result is the target computed in decode
  assign rename_wb_value = {cur_uop.target, 2'b00};

  rename_latch latch_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .stall      (rename_stall),
    .decode_uop (decode_uop),
    .cur_uop    (cur_uop)
  );

  alias_table rat_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .rs1       (cur_uop.rs1),
    .rs2       (cur_uop.rs2),
    .rs1_src   (rs1_src),
    .rs2_src   (rs2_src),
    .alloc     (alloc),
    .rd        (alloc_rd),
    .robid     (cur_uop.robid),
    .wb_valid  (wb_valid),
    .wb_robid  (wb_robid),
    .wb_value  (wb_value),
    .fwd_valid (rename_wb_valid),
    .fwd_robid (cur_uop.robid),
    .fwd_value (rename_wb_value)
  );

  operand_select opsel_i (
    .cur_uop (cur_uop),
    .rs1_src (rs1_src),
    .rs2_src (rs2_src),
    .op1     (op1),
    .op2     (op2)
  );

  dispatch_ctrl disp_i (
    .cur_uop     (cur_uop),
    .op1         (op1),
    .op2         (op2),
    .rob_head    (rob_head),
    .csr_busy    (csr_busy),
    .exers_stall (exers_stall),
    .lsq_stall   (lsq_stall),
    .exers_write (exers_write),
    .lsq_write   (lsq_write),
    .csr_write   (csr_write),
    .disp        (disp),
    .stall       (rename_stall),
    .alloc       (alloc),
    .alloc_rd    (alloc_rd),
    .fwd_valid   (rename_wb_valid),
    .wb_inhibit  (wb_inhibit)
  );

endmodule

`default_nettype wire

/* verification/rename_checker.sv */
// bound assertions on consumer exclusivity, stall hold and flush drop of the rename stage
`timescale 1ns/100ps
`default_nettype none

module rename_checker (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic flush,
  input wire logic exers_write,
  input wire logic lsq_write,
  input wire logic csr_write,
  input wire logic rename_stall
);

  // count of failed assertions
  int failures = 0;

  // one consumer per micro-op
  a_one_consumer: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({exers_write, lsq_write, csr_write}))
    else begin
      $error("more than one consumer strobe active");
      failures++;
    end

  // held micro-op keeps its strobe while stalled
  a_exers_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (exers_write && rename_stall && !flush) |=> exers_write)
    else begin
      $error("exers_write dropped while stalled");
      failures++;
    end

  a_lsq_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (lsq_write && rename_stall && !flush) |=> lsq_write)
    else begin
      $error("lsq_write dropped while stalled");
      failures++;
    end

  // a flushed micro-op never reaches a consumer
  a_flush_drop: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> !(exers_write || lsq_write || csr_write))
    else begin
      $error("consumer strobe raised after a flush");
      failures++;
    end

endmodule

bind rename_top rename_checker checker_i (
  .clk          (clk),
  .arst_n       (arst_n),
  .flush        (flush),
  .exers_write  (exers_write),
  .lsq_write    (lsq_write),
  .csr_write    (csr_write),
  .rename_stall (rename_stall)
);

`default_nettype wire

/* verification/rename_monitor.sv */
// compares rename stage outputs with the expected row values, counts tests and failures
`timescale 1ns/100ps
`default_nettype none

module rename_monitor (
  input  wire logic                          clk,
  input  wire logic                          check,
  input  wire logic                          idle_check,
  input  wire logic [95:0]                   name,
  input  wire rename_pkg::uop_t              exp_uop,
  input  wire logic [3:0]                    exp_strobes,
  input  wire rename_pkg::src_t              exp_op1,
  input  wire rename_pkg::src_t              exp_op2,
  input  wire logic                          exp_fwd_valid,
  input  wire logic                          exp_inhibit,
  input  wire logic [31:0]                   exp_fwd_value,
  input  wire logic [5:0]                    exp_rd,
  input  wire logic                          exers_write,
  input  wire logic                          lsq_write,
  input  wire logic                          csr_write,
  input  wire logic                          rename_stall,
  input  wire rename_pkg::dispatch_t         disp,
  input  wire logic                          rename_wb_valid,
  input  wire logic [31:0]                   rename_wb_value,
  input  wire logic                          wb_inhibit,
  output int                                 tests_run,
  output int                                 tests_failed
);

  int row_errors;

  task automatic compare(input string what, input logic [32:0] exp, input logic [32:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s expected %h actual %h", name, what, exp, act);
      row_errors++;
    end
  endtask

  initial begin
    tests_run = 0;
    tests_failed = 0;
  end

  always @(posedge clk) begin
    if (check) begin
      row_errors = 0;
      // strobe order exers, lsq, csr, stall
      compare("strobes", 33'(exp_strobes),
              33'({exers_write, lsq_write, csr_write, rename_stall}));
      compare("op", 33'(exp_uop.op), 33'(disp.op));
      compare("robid", 33'(exp_uop.robid), 33'(disp.robid));
      compare("imm", 33'(exp_uop.imm), 33'(disp.imm));
      compare("op1", exp_op1, disp.op1);
      compare("op2", exp_op2, disp.op2);
      compare("rd", 33'(exp_rd), 33'(disp.rd));
      compare("fwd_valid", 33'(exp_fwd_valid), 33'(rename_wb_valid));
      // forwarded value only matters while the forward strobe is up
      if (exp_fwd_valid) begin
        compare("fwd_value", 33'(exp_fwd_value), 33'(rename_wb_value));
      end
      compare("inhibit", 33'(exp_inhibit), 33'(wb_inhibit));
      tests_run++;
      if (row_errors != 0) begin
        tests_failed++;
        $display("test %s: %0d errors", name, row_errors);
      end else begin
        $display("test %s: ok", name);
      end
    end
    // dropped micro-op must not reach any consumer
    if (idle_check && (exers_write || lsq_write || csr_write || rename_stall)) begin
      $display("after the flush in %s the dropped micro-op still drives a strobe", name);
      tests_failed++;
    end
  end

endmodule

`default_nettype wire

/* verification/rename_tb.sv */
// testbench for the rename stage, applies a table of micro-ops and side inputs row by row
`timescale 1ns/100ps
`default_nettype none

module rename_tb;

  localparam int period = 4;

  typedef struct packed {
    logic [6:0] rob_head;
    logic csr_busy;
    logic exers_stall;
    logic lsq_stall;
    logic flush;
    logic wb_valid;
    logic [6:0] wb_robid;
    logic [31:0] wb_value;
  } side_t;

  typedef struct packed {
    logic [95:0] name;
    rename_pkg::uop_t uop;
    side_t side;
    logic [3:0] exp_strobes;
    rename_pkg::src_t exp_op1;
    rename_pkg::src_t exp_op2;
    logic exp_fwd_valid;
    logic exp_inhibit;
    logic [31:0] exp_fwd_value;
    logic [5:0] exp_rd;
  } row_t;

  logic clk;
  logic arst_n;
  logic flush;
  rename_pkg::uop_t decode_uop;
  logic [6:0] rob_head;
  logic csr_busy;
  logic exers_stall;
  logic lsq_stall;
  logic wb_valid;
  logic [6:0] wb_robid;
  logic [31:0] wb_value;
  logic rename_stall;
  logic exers_write;
  logic lsq_write;
  logic csr_write;
  rename_pkg::dispatch_t disp;
  logic rename_wb_valid;
  logic [31:0] rename_wb_value;
  logic wb_inhibit;

  logic check;
  logic idle_check;
  logic table_ready;
  row_t cur_row;
  row_t rows[$];
  int tests_run;
  int tests_failed;
  int seed;

  always #(period / 2) clk = ~clk;

  rename_top dut_i (
    .clk (clk), .arst_n (arst_n), .flush (flush), .decode_uop (decode_uop),
    .rename_stall (rename_stall), .rob_head (rob_head), .csr_busy (csr_busy),
    .exers_stall (exers_stall), .lsq_stall (lsq_stall), .wb_valid (wb_valid),
    .wb_robid (wb_robid), .wb_value (wb_value), .exers_write (exers_write),
    .lsq_write (lsq_write), .csr_write (csr_write), .disp (disp),
    .rename_wb_valid (rename_wb_valid), .rename_wb_value (rename_wb_value),
    .wb_inhibit (wb_inhibit)
  );

  rename_monitor mon_i (
    .clk (clk), .check (check), .idle_check (idle_check), .name (cur_row.name),
    .exp_uop (cur_row.uop),
    .exp_strobes (cur_row.exp_strobes), .exp_op1 (cur_row.exp_op1),
    .exp_op2 (cur_row.exp_op2), .exp_fwd_valid (cur_row.exp_fwd_valid),
    .exp_inhibit (cur_row.exp_inhibit), .exp_fwd_value (cur_row.exp_fwd_value),
    .exp_rd (cur_row.exp_rd), .exers_write (exers_write), .lsq_write (lsq_write),
    .csr_write (csr_write), .rename_stall (rename_stall), .disp (disp),
    .rename_wb_valid (rename_wb_valid), .rename_wb_value (rename_wb_value),
    .wb_inhibit (wb_inhibit), .tests_run (tests_run), .tests_failed (tests_failed)
  );

  function automatic rename_pkg::uop_t new_uop(input logic [6:0] robid, input logic [5:0] rd);
    rename_pkg::uop_t u;
    u = '0;
    u.valid = 1'b1;
    // opcode is only carried through to the consumer
    u.op = 5'($random(seed));
    u.robid = robid;
    u.rd = rd;
    return u;
  endfunction

  function automatic rename_pkg::src_t ready_src(input logic [31:0] v);
    rename_pkg::src_t s;
    s = '0;
    s.ready = 1'b1;
    s.data.value = v;
    return s;
  endfunction

  function automatic rename_pkg::src_t pending_src(input logic [6:0] tag);
    rename_pkg::src_t s;
    s = '0;
    s.data.tag.robid = tag;
    return s;
  endfunction

  // forward strobes follow from the micro-op and the expected stall
  task automatic add_row(input logic [95:0] name, input rename_pkg::uop_t u, input side_t s,
                         input logic [3:0] strobes, input rename_pkg::src_t op1,
                         input rename_pkg::src_t op2);
    row_t r;
    r.name = name;
    r.uop = u;
    r.side = s;
    r.exp_strobes = strobes;
    r.exp_op1 = op1;
    r.exp_op2 = op2;
    r.exp_fwd_valid = u.forward & ~strobes[0];
    r.exp_inhibit = u.inhibit & ~strobes[0];
    r.exp_fwd_value = '0;
    r.exp_rd = u.forward ? (u.rd | 6'h20) : u.rd;
    rows.push_back(r);
  endtask

  task automatic apply_side(input side_t s);
    rob_head = s.rob_head;
    csr_busy = s.csr_busy;
    exers_stall = s.exers_stall;
    lsq_stall = s.lsq_stall;
    flush = s.flush;
    wb_valid = s.wb_valid;
    wb_robid = s.wb_robid;
    wb_value = s.wb_value;
  endtask

  task automatic build_table();
    rename_pkg::uop_t u;
    side_t s;
    logic [31:0] imm_a;
    logic [31:0] imm_b;
    seed = 32538;
    imm_a = $random(seed);
    imm_b = $random(seed);
    u = new_uop(7'd1, 6'h20);
    u.uses_pc = 1'b1;
    u.addr = 30'h40;
    u.imm = imm_a;
    add_row("auipc", u, '0, 4'b1000, ready_src(32'h100), ready_src(imm_a));
    u = new_uop(7'd2, 6'h20);
    u.imm = imm_b;
    add_row("lui", u, '0, 4'b1000, ready_src(imm_b), ready_src(32'h0));
    u = new_uop(7'd3, 6'h20);
    u.csr_access = 1'b1;
    u.rs1 = 5'h13;
    s = '0;
    s.rob_head = 7'd3;
    add_row("csr_imm", u, s, 4'b0010, ready_src(32'h13), ready_src(32'h0));
    // renaming of x5 and its writeback
    u = new_uop(7'd10, 6'd5);
    u.uses_rs1 = 1'b1;
    u.uses_imm = 1'b1;
    u.imm = imm_a;
    add_row("addi_x5", u, '0, 4'b1000, ready_src(32'h0), ready_src(imm_a));
    u = new_uop(7'd11, 6'h20);
    u.uses_rs1 = 1'b1;
    u.uses_rs2 = 1'b1;
    u.rs1 = 5'd5;
    s = '0;
    s.wb_valid = 1'b1;
    s.wb_robid = 7'd10;
    s.wb_value = 32'h1234_5678;
    add_row("rd_pend", u, s, 4'b1000, pending_src(7'd10), ready_src(32'h0));
    u = new_uop(7'd12, 6'h20);
    u.uses_rs1 = 1'b1;
    u.uses_imm = 1'b1;
    u.rs1 = 5'd5;
    u.imm = 32'd4;
    add_row("rd_ready", u, '0, 4'b1000, ready_src(32'h1234_5678), ready_src(32'd4));
    u.robid = 7'd13;
    u.uses_memory = 1'b1;
    add_row("load", u, '0, 4'b0100, ready_src(32'h1234_5678), ready_src(32'd4));
    // back-pressure keeps the strobe up
    u = new_uop(7'd14, 6'h20);
    u.uses_rs1 = 1'b1;
    u.uses_rs2 = 1'b1;
    u.uses_memory = 1'b1;
    u.rs1 = 5'd5;
    u.rs2 = 5'd5;
    s = '0;
    s.lsq_stall = 1'b1;
    add_row("lsq_stall", u, s, 4'b0101, ready_src(32'h1234_5678),
            ready_src(32'h1234_5678));
    u = new_uop(7'd15, 6'h20);
    u.uses_rs1 = 1'b1;
    u.uses_imm = 1'b1;
    u.imm = 32'd1;
    s = '0;
    s.exers_stall = 1'b1;
    add_row("exe_stall", u, s, 4'b1001, ready_src(32'h0), ready_src(32'd1));
    // CSR waits for the ROB head
    u = new_uop(7'd20, 6'h20);
    u.csr_access = 1'b1;
    u.uses_rs1 = 1'b1;
    u.uses_imm = 1'b1;
    u.rs1 = 5'd5;
    u.imm = 32'h300;
    s = '0;
    s.rob_head = 7'd19;
    add_row("csr_wait", u, s, 4'b0001, ready_src(32'h1234_5678), ready_src(32'h300));
    u.robid = 7'd21;
    s.rob_head = 7'd21;
    add_row("csr_go", u, s, 4'b0010, ready_src(32'h1234_5678), ready_src(32'h300));
    u.robid = 7'd22;
    s.rob_head = 7'd22;
    s.csr_busy = 1'b1;
    add_row("csr_busy", u, s, 4'b0011, ready_src(32'h1234_5678), ready_src(32'h300));
    // forwarded jump link value
    u = new_uop(7'd30, 6'd7);
    u.uses_pc = 1'b1;
    u.addr = 30'h80;
    u.imm = 32'd8;
    u.forward = 1'b1;
    u.inhibit = 1'b1;
    u.target = 30'h100;
    add_row("fwd_jal", u, '0, 4'b1000, ready_src(32'h200), ready_src(32'd8));
    // link value is the word target as a byte address
    rows[rows.size() - 1].exp_fwd_value = 32'h400;
    u = new_uop(7'd31, 6'h20);
    u.uses_rs1 = 1'b1;
    u.uses_imm = 1'b1;
    u.rs1 = 5'd7;
    add_row("fwd_use", u, '0, 4'b1000, ready_src(32'h400), ready_src(32'h0));
    // flush while an LSQ op is held
    u = new_uop(7'd40, 6'd8);
    u.uses_rs1 = 1'b1;
    u.uses_imm = 1'b1;
    add_row("flush_a", u, '0, 4'b1000, ready_src(32'h0), ready_src(32'h0));
    u = new_uop(7'd41, 6'h20);
    u.uses_rs1 = 1'b1;
    u.uses_imm = 1'b1;
    u.uses_memory = 1'b1;
    u.rs1 = 5'd8;
    s = '0;
    s.lsq_stall = 1'b1;
    s.flush = 1'b1;
    add_row("flush_hold", u, s, 4'b0101, pending_src(7'd40), ready_src(32'h0));
    u = new_uop(7'd42, 6'h20);
    u.uses_rs1 = 1'b1;
    u.uses_rs2 = 1'b1;
    u.rs1 = 5'd8;
    add_row("flush_read", u, '0, 4'b1000, ready_src(32'h0), ready_src(32'h0));
  endtask

  initial begin
    side_t s;
    clk = 1'b0;
    arst_n = 1'b0;
    decode_uop = '0;
    check = 1'b0;
    idle_check = 1'b0;
    table_ready = 1'b0;
    cur_row = '0;
    apply_side('0);
    build_table();
    table_ready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    foreach (rows[i]) begin
      @(negedge clk);
      idle_check = 1'b0;
      decode_uop = rows[i].uop;
      s = '0;
      s.rob_head = rows[i].side.rob_head;
      apply_side(s);
      @(negedge clk);
      decode_uop = '0;
      apply_side(rows[i].side);
      cur_row = rows[i];
      check = 1'b1;
      // drain lets a held micro-op leave
      @(negedge clk);
      check = 1'b0;
      idle_check = rows[i].side.flush;
      s = '0;
      s.rob_head = rows[i].uop.robid;
      apply_side(s);
    end
    @(negedge clk);
    idle_check = 1'b0;
    @(negedge clk);
    $display("tests run %0d, failed %0d, assertion failures %0d", tests_run, tests_failed,
             dut_i.checker_i.failures);
    if (tests_failed == 0 && tests_run == rows.size() && dut_i.checker_i.failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // each row takes three cycles, twenty leaves ample margin
  initial begin
    wait (table_ready);
    repeat (rows.size() * 20) @(posedge clk);
    $display("watchdog timeout, the test sequence did not finish");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
src/rename_pkg.sv
src/rename_latch.sv
src/alias_table.sv
src/operand_select.sv
src/dispatch_ctrl.sv
src/rename_top.sv
verification/rename_checker.sv
verification/rename_monitor.sv
verification/rename_tb.sv

/* Makefile */
# Verilator build and run of the rename stage testbench

VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
